//--- hdl/keypad_macros.svh
`ifndef KEYPAD_MACROS_SVH
`define KEYPAD_MACROS_SVH

// ********************
// keypad geometry
// ********************

// rows and columns of the matrix
`define KEYPAD_WIDTH 4

// debounce pause after a decoded press, in clocks
`define KEYPAD_PAUSE_CYCLES 16

// ********************
// FIFO and bus
// ********************

`define KEY_FIFO_DEPTH 8 // power of two, at most 8 with a 4-bit count

// byte address width of the register block
`define AXIL_ADDR_WIDTH 4

`endif

//--- hdl/axil_pkg.sv
package axil_pkg;

	// ********************
	// AXI4-Lite responses
	// ********************
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10  // write to read-only or unmapped offset
	} axil_resp_t;

	// ********************
	// register map
	// ********************
	// byte offsets inside the 16-byte window
	typedef enum logic [3:0] {
		STATUS = 4'h0, // not-empty, sticky overflow, count
		KEY    = 4'h4, // pop on read
		CTRL   = 4'h8  // scan enable, irq enable, overflow clear
	} reg_offset_t;

	// CTRL bit positions
	localparam int CTRL_SCAN_EN = 0;
	localparam int CTRL_IRQ_EN  = 1;
	localparam int CTRL_OVF_CLR = 2;

	// valid flag in a KEY read
	localparam int KEY_VALID_BIT = 8;

endpackage

//--- hdl/keypad_pkg.sv
package keypad_pkg;

	// one hex key value per press
	typedef logic [3:0] key_code_t;

	// scanner FSM states
	typedef enum logic [1:0] {
		SCAN    = 2'd0, // looking for a press
		PAUSE   = 2'd1, // debounce wait after an event
		RELEASE = 2'd2  // waiting for the key to let go
	} scan_state_t;

	// ********************
	// key legend
	// ********************
	// rows top to bottom, columns left to right
	function automatic key_code_t key_legend(input logic [1:0] row, input logic [1:0] col);
		key_code_t code;
		case ({row, col})
			4'b00_00: code = 4'h1;
			4'b00_01: code = 4'h2;
			4'b00_10: code = 4'h3;
			4'b00_11: code = 4'hA;
			4'b01_00: code = 4'h4;
			4'b01_01: code = 4'h5;
			4'b01_10: code = 4'h6;
			4'b01_11: code = 4'hB;
			4'b10_00: code = 4'h7;
			4'b10_01: code = 4'h8;
			4'b10_10: code = 4'h9;
			4'b10_11: code = 4'hC;
			4'b11_00: code = 4'hE; // bottom row is E 0 F D
			4'b11_01: code = 4'h0;
			4'b11_10: code = 4'hF;
			4'b11_11: code = 4'hD;
			default:  code = 4'h0;
		endcase
		return code;
	endfunction

endpackage

//--- hdl/keypad_scan.sv
`timescale 1ns/10ps

`include "keypad_macros.svh"

module keypad_scan (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      scan_en,
	input  logic [`KEYPAD_WIDTH-1:0]  col_n,
	output logic [`KEYPAD_WIDTH-1:0]  row_n,
	output logic                      key_valid,
	output keypad_pkg::key_code_t     key
);
	import keypad_pkg::*;

	localparam int SEL_W   = $clog2(`KEYPAD_WIDTH);
	localparam int NLOW_W  = $clog2(`KEYPAD_WIDTH + 1);
	localparam int PAUSE_W = $clog2(`KEYPAD_PAUSE_CYCLES);

	localparam logic [PAUSE_W-1:0] PAUSE_LAST = PAUSE_W'(`KEYPAD_PAUSE_CYCLES - 1);
	localparam logic [SEL_W-1:0]   REL_LAST   = SEL_W'(`KEYPAD_WIDTH - 1);

	logic [SEL_W-1:0]   sel;       // active row index
	logic [SEL_W-1:0]   col_idx;   // last low column seen
	logic [NLOW_W-1:0]  n_low;     // number of low columns
	logic               hit;       // exactly one column low on the active row
	logic               detect;    // new press taken in SCAN
	scan_state_t        state_q;
	logic [PAUSE_W-1:0] pause_cnt;
	logic [SEL_W-1:0]   rel_cnt;   // clean cycles seen in RELEASE

	// ********************
	// row drive
	// ********************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sel <= '0;
		else
			sel <= sel + 1'b1; // one row per clock
	end

	// only the selected row pulled low
	assign row_n = ~(`KEYPAD_WIDTH'(1) << sel);

	// ********************
	// column decode
	// ********************
	always_comb
	begin
		n_low = '0;
		col_idx = '0;
		for (int c = 0; c < `KEYPAD_WIDTH; c++)
		begin
			if (!col_n[c])
			begin
				n_low = n_low + 1'b1;
				col_idx = SEL_W'(c);
			end
		end
	end

	assign hit = (n_low == NLOW_W'(1)); // two keys at once count as nothing
	assign detect = scan_en && hit && (state_q == SCAN);

	// ********************
	// scan FSM
	// ********************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= SCAN;
			pause_cnt <= '0;
			rel_cnt <= '0;
			key_valid <= 1'b0;
		end
		else
		begin
			key_valid <= detect; // one clock after decode
			if (!scan_en)
				state_q <= SCAN; // rows keep cycling, nothing reported
			else
			begin
				case (state_q)
					SCAN:
					begin
						if (hit)
						begin
							state_q <= PAUSE;
							pause_cnt <= '0;
						end
					end
					PAUSE:
					begin
						if (pause_cnt == PAUSE_LAST)
						begin
							state_q <= RELEASE;
							rel_cnt <= '0;
						end
						else
							pause_cnt <= pause_cnt + 1'b1;
					end
					RELEASE:
					begin
						if (hit)
							rel_cnt <= '0; // still held, start over
						else if (rel_cnt == REL_LAST)
							state_q <= SCAN; // a full row sweep with no key
						else
							rel_cnt <= rel_cnt + 1'b1;
					end
					default:
						state_q <= SCAN;
				endcase
			end
		end
	end

	// code is only looked at with key_valid
	always_ff @(posedge clk)
	begin
		if (detect)
			key <= key_legend(sel, col_idx);
	end

	// ********************
	// checks
	// ********************
	a_single_event: assert property (@(posedge clk) disable iff (!rst_n)
		key_valid |=> !key_valid);

	a_one_row: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~row_n));

endmodule

//--- hdl/key_fifo.sv
`timescale 1ns/10ps

`include "keypad_macros.svh"

module key_fifo (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   push,
	input  keypad_pkg::key_code_t  push_key,
	input  logic                   pop,
	output keypad_pkg::key_code_t  rd_key,
	output logic                   empty,
	output logic [3:0]             count,
	output logic                   overflow
);
	import keypad_pkg::*;

	localparam int         AW    = $clog2(`KEY_FIFO_DEPTH);
	localparam logic [3:0] DEPTH = 4'(`KEY_FIFO_DEPTH);

	key_code_t       mem [`KEY_FIFO_DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic            full;
	logic            do_push;
	logic            do_pop;

	assign full    = (count == DEPTH);
	assign empty   = (count == 4'd0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty; // pop on empty ignored

	assign rd_key = mem[rd_ptr]; // head, valid while not empty

	// ********************
	// pointers and count
	// ********************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			overflow <= push && full; // code dropped this cycle
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1; // wraps with power of two depth
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_key;
	end

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= DEPTH);

endmodule

//--- hdl/keypad_axil_regs.sv
`timescale 1ns/10ps

`include "keypad_macros.svh"

module keypad_axil_regs (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [`AXIL_ADDR_WIDTH-1:0]  awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [31:0]                  wdata,
	input  logic [3:0]                   wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output axil_pkg::axil_resp_t         bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [`AXIL_ADDR_WIDTH-1:0]  araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [31:0]                  rdata,
	output axil_pkg::axil_resp_t         rresp,
	output logic                         rvalid,
	input  logic                         rready,
	input  logic                         fifo_empty,
	input  logic [3:0]                   fifo_count,
	input  keypad_pkg::key_code_t        fifo_key,
	input  logic                         fifo_overflow,
	output logic                         fifo_pop,
	output logic                         scan_en,
	output logic                         irq
);
	import axil_pkg::*;

	logic        wr_hs;      // write address and data taken
	logic        rd_hs;      // read address taken
	logic        wr_ctrl;    // accepted write hits CTRL
	logic        ovf_clr;
	logic        irq_en;
	logic        ovf_sticky;
	logic [31:0] rd_word;
	axil_resp_t  rd_resp;

	assign wr_hs   = awready && awvalid && wvalid;
	assign rd_hs   = arready && arvalid;
	assign wr_ctrl = wr_hs && (reg_offset_t'(awaddr) == CTRL);
	assign ovf_clr = wr_ctrl && wstrb[0] && wdata[CTRL_OVF_CLR];

	// pop in the accept cycle, never on empty
	assign fifo_pop = rd_hs && (reg_offset_t'(araddr) == KEY) && !fifo_empty;

	// ********************
	// handshakes
	// ********************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			// single-cycle ready, blocked while a response is out
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			arready <= arvalid && !arready && !rvalid;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	// response payloads
	always_ff @(posedge clk)
	begin
		if (wr_hs)
			bresp <= wr_ctrl ? OKAY : SLVERR; // STATUS, KEY and holes are read only
		if (rd_hs)
		begin
			rdata <= rd_word;
			rresp <= rd_resp;
		end
	end

	// ********************
	// read mux
	// ********************
	always_comb
	begin
		rd_word = '0;
		rd_resp = OKAY;
		case (reg_offset_t'(araddr))
			STATUS:
				rd_word = {24'd0, fifo_count, 2'd0, ovf_sticky, ~fifo_empty};
			KEY:
			begin
				if (!fifo_empty)
					rd_word = {23'd0, 1'b1, 4'd0, fifo_key}; // bit 8 valid
			end
			CTRL:
				rd_word = {30'd0, irq_en, scan_en};
			default:
				rd_resp = SLVERR;
		endcase
	end

	// ********************
	// control state
	// ********************
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			scan_en <= 1'b0;
			irq_en <= 1'b0;
			ovf_sticky <= 1'b0;
			irq <= 1'b0;
		end
		else
		begin
			if (wr_ctrl && wstrb[0])
			begin
				scan_en <= wdata[CTRL_SCAN_EN];
				irq_en <= wdata[CTRL_IRQ_EN];
			end
			if (ovf_clr)
				ovf_sticky <= 1'b0;
			if (fifo_overflow)
				ovf_sticky <= 1'b1; // a fresh drop beats the clear
			irq <= irq_en && !fifo_empty;
		end
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid);

	a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> $stable(rdata));

endmodule

//--- hdl/keypad_ctrl_top.sv
`timescale 1ns/10ps

`include "keypad_macros.svh"

module keypad_ctrl_top (
	input  logic                         clk,
	input  logic                         rst_n,
	output logic [`KEYPAD_WIDTH-1:0]     row_n,
	input  logic [`KEYPAD_WIDTH-1:0]     col_n,
	input  logic [`AXIL_ADDR_WIDTH-1:0]  awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [31:0]                  wdata,
	input  logic [3:0]                   wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output axil_pkg::axil_resp_t         bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [`AXIL_ADDR_WIDTH-1:0]  araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [31:0]                  rdata,
	output axil_pkg::axil_resp_t         rresp,
	output logic                         rvalid,
	input  logic                         rready,
	output logic                         irq
);
	import keypad_pkg::*;

	logic       key_valid;
	key_code_t  key;
	logic       scan_en;
	// FIFO to register block
	logic       fifo_pop;
	key_code_t  rd_key;
	logic [3:0] fifo_count;
	logic       fifo_empty;
	logic       fifo_overflow;

	keypad_scan i_scan (.clk(clk), .rst_n(rst_n), .scan_en(scan_en), .col_n(col_n),
		.row_n(row_n), .key_valid(key_valid), .key(key));

	key_fifo i_fifo (.clk(clk), .rst_n(rst_n), .push(key_valid), .push_key(key),
		.pop(fifo_pop), .rd_key(rd_key), .empty(fifo_empty), .count(fifo_count),
		.overflow(fifo_overflow));

	keypad_axil_regs i_regs (.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.fifo_empty(fifo_empty), .fifo_count(fifo_count), .fifo_key(rd_key),
		.fifo_overflow(fifo_overflow), .fifo_pop(fifo_pop),
		.scan_en(scan_en), .irq(irq));

endmodule

//--- test/keypad_ctrl_checker.sv
`timescale 1ns/10ps

`include "keypad_macros.svh"

module keypad_ctrl_checker (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [`AXIL_ADDR_WIDTH-1:0]  awaddr,
	input  logic                         awvalid,
	input  logic                         awready,
	input  logic [31:0]                  wdata,
	input  logic [3:0]                   wstrb,
	input  logic                         wvalid,
	input  logic                         wready,
	input  axil_pkg::axil_resp_t         bresp,
	input  logic                         bvalid,
	input  logic                         bready,
	input  logic [`AXIL_ADDR_WIDTH-1:0]  araddr,
	input  logic                         arvalid,
	input  logic                         arready,
	input  logic [31:0]                  rdata,
	input  axil_pkg::axil_resp_t         rresp,
	input  logic                         rvalid,
	input  logic                         rready,
	input  logic                         irq,
	input  logic                         press_done,  // key released and settled
	input  logic [1:0]                   press_row,
	input  logic [1:0]                   press_col,
	input  logic                         status_poll, // polling reads whose data is not compared
	input  logic                         irq_check,
	input  logic                         test_done,
	input  int                           test_id,
	output int                           n_checks,
	output int                           n_errors
);
	import axil_pkg::*;

	// hex legend with four digits per row and row 0 first
	localparam logic [63:0] LEGEND = 64'h123A_456B_789C_E0FD;

	logic [3:0]  model_q [$]; // model FIFO with the oldest first
	logic        model_ovf;
	logic        model_scan_en;
	logic        model_irq_en;
	logic [31:0] exp_rdata;
	axil_resp_t  exp_rresp;
	axil_resp_t  exp_bresp;
	logic        skip_rdata;
	int          test_errors;

	function automatic logic [3:0] legend_code(input logic [1:0] row, input logic [1:0] col);
		int idx;
		idx = 4 * int'(row) + int'(col);
		return LEGEND[63 - 4 * idx -: 4];
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			test_errors++;
			$display("ERR %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	// ********************
	// bus and model
	// ********************
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			model_q.delete();
			model_ovf = 1'b0;
			model_scan_en = 1'b0;
			model_irq_en = 1'b0;
			skip_rdata = 1'b0;
			n_checks = 0;
			n_errors = 0;
			test_errors = 0;
		end
		else
		begin
			// the two write readies pulse together
			if (awready || wready)
				compare("wready", 32'(wready), 32'(awready));
			if (bvalid && bready)
				compare("bresp", 32'(bresp), 32'(exp_bresp));
			if (rvalid && rready)
			begin
				compare("rresp", 32'(rresp), 32'(exp_rresp));
				if (!skip_rdata)
					compare("rdata", rdata, exp_rdata);
			end
			if (awvalid && awready && wvalid && wready)
			begin
				exp_bresp = (awaddr == CTRL) ? OKAY : SLVERR;
				if (awaddr == CTRL && wstrb[0])
				begin
					model_scan_en = wdata[0];
					model_irq_en = wdata[1];
					if (wdata[2])
						model_ovf = 1'b0; // write-one clear
				end
			end
			if (arvalid && arready)
			begin
				exp_rresp = OKAY;
				exp_rdata = '0;
				skip_rdata = status_poll;
				case (araddr)
					STATUS:
						exp_rdata = {24'd0, 4'(model_q.size()), 2'd0, model_ovf,
							model_q.size() != 0};
					KEY:
					begin
						if (model_q.size() != 0)
							exp_rdata = {23'd0, 1'b1, 4'd0, model_q.pop_front()};
					end
					CTRL:
						exp_rdata = {30'd0, model_irq_en, model_scan_en};
					default:
					begin
						exp_rresp = SLVERR;
						skip_rdata = 1'b1;
					end
				endcase
			end
			// one event per press while scanning
			if (press_done && model_scan_en)
			begin
				if (model_q.size() < `KEY_FIFO_DEPTH)
					model_q.push_back(legend_code(press_row, press_col));
				else
					model_ovf = 1'b1; // dropped
			end
			if (irq_check)
				compare("irq", 32'(irq), 32'(model_irq_en && model_q.size() != 0));
			if (test_done)
			begin
				$display("test %0d %s, %0d errors", test_id,
					(test_errors == 0) ? "passed" : "FAILED", test_errors);
				test_errors = 0;
			end
		end
	end

endmodule

//--- test/keypad_ctrl_tb.sv
`timescale 1ns/10ps

`include "keypad_macros.svh"

module keypad_ctrl_tb;
	import axil_pkg::*;

	localparam int TMO = 100; // clocks per handshake wait

	logic                         clk = 1'b0;
	logic                         rst_n;
	logic [`KEYPAD_WIDTH-1:0]     row_n;
	logic [`KEYPAD_WIDTH-1:0]     col_n;
	logic [`AXIL_ADDR_WIDTH-1:0]  awaddr;
	logic                         awvalid;
	logic                         awready;
	logic [31:0]                  wdata;
	logic [3:0]                   wstrb;
	logic                         wvalid;
	logic                         wready;
	axil_resp_t                   bresp;
	logic                         bvalid;
	logic                         bready;
	logic [`AXIL_ADDR_WIDTH-1:0]  araddr;
	logic                         arvalid;
	logic                         arready;
	logic [31:0]                  rdata;
	axil_resp_t                   rresp;
	logic                         rvalid;
	logic                         rready;
	logic                         irq;
	// keypad model
	logic                         key_down;
	logic [1:0]                   key_row;
	logic [1:0]                   key_col;
	// strobes to the checker
	logic                         press_done;
	logic [1:0]                   press_row;
	logic [1:0]                   press_col;
	logic                         status_poll;
	logic                         irq_check;
	logic                         test_done;
	int                           test_id;
	int                           n_checks;
	int                           n_errors;
	int                           seed = 7;
	logic [31:0]                  rnd;
	logic [31:0]                  word;

	always #4 clk = ~clk;

	// held key pulls its column low while its row is driven
	assign col_n = (key_down && !row_n[key_row]) ? ~(`KEYPAD_WIDTH'(1) << key_col) : '1;

	keypad_ctrl_top i_dut (.clk(clk), .rst_n(rst_n), .row_n(row_n), .col_n(col_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready), .irq(irq));

	keypad_ctrl_checker i_chk (.clk(clk), .rst_n(rst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready), .irq(irq),
		.press_done(press_done), .press_row(press_row), .press_col(press_col),
		.status_poll(status_poll), .irq_check(irq_check),
		.test_done(test_done), .test_id(test_id),
		.n_checks(n_checks), .n_errors(n_errors));

	task automatic finish_run(input logic aborted);
		$display("summary: %0d checks, %0d errors", n_checks, n_errors);
		if (aborted || n_errors != 0)
			$display("Done: errors found");
		else
			$display("Done: no errors");
		$finish;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		finish_run(1'b1);
	endtask

	// ********************
	// bus tasks
	// ********************
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
		int t;
		int stall;
		logic [31:0] r;
		r = $random(seed);
		stall = int'(r[1:0]); // bready held off up to three clocks
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		t = 0;
		do
		begin
			@(posedge clk);
			t++;
		end
		while (!awready && t < TMO);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		if (!awready)
			abort_run("timeout: write address and data were never accepted");
		t = 0;
		do
		begin
			@(posedge clk);
			t++;
		end
		while (!bvalid && t < TMO);
		if (!bvalid)
			abort_run("timeout: no write response came back");
		repeat (stall) @(posedge clk);
		bready <= 1'b1;
		@(posedge clk);
		bready <= 1'b0;
		if (!bvalid)
			abort_run("write response was withdrawn before bready");
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
		int t;
		int stall;
		logic [31:0] r;
		r = $random(seed);
		stall = int'(r[1:0]); // rready held off up to three clocks
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		t = 0;
		do
		begin
			@(posedge clk);
			t++;
		end
		while (!arready && t < TMO);
		arvalid <= 1'b0;
		if (!arready)
			abort_run("timeout: read address was never accepted");
		t = 0;
		do
		begin
			@(posedge clk);
			t++;
		end
		while (!rvalid && t < TMO);
		if (!rvalid)
			abort_run("timeout: no read data came back");
		repeat (stall) @(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
		if (!rvalid)
			abort_run("read data was withdrawn before rready");
		data = rdata;
	endtask

	// ********************
	// keypad and strobes
	// ********************
	task automatic press_key(input logic [1:0] row, input logic [1:0] col,
		input logic expect_event, input int hold);
		logic [31:0] prev_status;
		logic [31:0] now;
		int tries;
		status_poll <= 1'b1;
		axil_read(4'h0, prev_status);
		key_row <= row;
		key_col <= col;
		key_down <= 1'b1;
		now = prev_status;
		tries = 0;
		while (expect_event && now == prev_status && tries < 20) // several clocks per read
		begin
			axil_read(4'h0, now);
			tries++;
		end
		if (expect_event && now == prev_status)
			abort_run("timeout: key press never showed up in STATUS");
		repeat (hold) @(posedge clk);
		key_down <= 1'b0;
		status_poll <= 1'b0;
		repeat (30) @(posedge clk);
		press_row <= row;
		press_col <= col;
		press_done <= 1'b1;
		@(posedge clk);
		press_done <= 1'b0;
	endtask

	task automatic check_irq();
		repeat (2) @(posedge clk); // irq is one clock behind
		irq_check <= 1'b1;
		@(posedge clk);
		irq_check <= 1'b0;
	endtask

	task automatic end_test(input int id);
		@(posedge clk);
		test_id <= id;
		test_done <= 1'b1;
		@(posedge clk);
		test_done <= 1'b0;
		@(posedge clk);
	endtask

	// ********************
	// test sequence
	// ********************
	initial
	begin
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hF;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		key_down = 1'b0;
		key_row = '0;
		key_col = '0;
		press_done = 1'b0;
		press_row = '0;
		press_col = '0;
		status_poll = 1'b0;
		irq_check = 1'b0;
		test_done = 1'b0;
		test_id = 0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// reset values
		axil_read(4'h0, word);
		axil_read(4'h8, word);
		axil_read(4'h4, word);
		check_irq();
		end_test(1);

		// random keys come back in order
		axil_write(4'h8, 32'h1);
		for (int i = 0; i < 6; i++)
		begin
			rnd = $random(seed);
			press_key(rnd[1:0], rnd[3:2], 1'b1, 0);
		end
		for (int i = 0; i < 6; i++)
			axil_read(4'h4, word);
		axil_read(4'h0, word);
		end_test(2);

		// long hold gives a single event
		rnd = $random(seed);
		press_key(rnd[1:0], rnd[3:2], 1'b1, 200);
		axil_read(4'h0, word);
		axil_read(4'h4, word);
		end_test(3);

		// the ninth press overflows and the tenth changes nothing visible
		for (int i = 0; i < 10; i++)
		begin
			rnd = $random(seed);
			press_key(rnd[1:0], rnd[3:2], i < 9, 20);
		end
		axil_read(4'h0, word);
		for (int i = 0; i < 8; i++)
			axil_read(4'h4, word);
		axil_write(4'h8, 32'h5); // keep scanning and clear overflow
		axil_read(4'h0, word);
		end_test(4);

		// irq and then scanning off
		axil_write(4'h8, 32'h3);
		rnd = $random(seed);
		press_key(rnd[1:0], rnd[3:2], 1'b1, 0);
		check_irq();
		axil_read(4'h4, word);
		check_irq();
		axil_write(4'h8, 32'h2);
		press_key(rnd[1:0], rnd[3:2], 1'b0, 20);
		axil_read(4'h0, word);
		check_irq();
		end_test(5);

		// illegal accesses
		axil_write(4'h8, 32'h1);
		press_key(2'd3, 2'd1, 1'b1, 0);
		axil_write(4'h0, 32'hFFFF_FFFF);
		axil_write(4'h4, 32'hFFFF_FFFF);
		axil_write(4'hC, 32'hFFFF_FFFF);
		axil_read(4'hC, word);
		axil_read(4'h0, word);
		axil_read(4'h8, word);
		axil_read(4'h4, word);
		end_test(6);

		finish_run(1'b0);
	end

endmodule

//--- keypad_ctrl_top.f
+incdir+hdl
hdl/axil_pkg.sv
hdl/keypad_pkg.sv
hdl/keypad_scan.sv
hdl/key_fifo.sv
hdl/keypad_axil_regs.sv
hdl/keypad_ctrl_top.sv
test/keypad_ctrl_checker.sv
test/keypad_ctrl_tb.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := keypad_ctrl_tb
FLIST := keypad_ctrl_top.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
